// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_div_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "All tests passed" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/div_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module div_ctrl (
  input  logic clock,
  input  logic nreset,
  input  logic in_valid_i,
  output logic in_ready_o,
  output logic out_valid_o,
  input  logic out_ready_i,
  input  logic skip_i,  // zero operand, no iteration needed
  input  logic last_i,  // current step is bit zero
  output logic load_o,  // latch operands this edge
  output logic step_o   // one quotient bit this edge
);
  import div_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  always_comb
  begin
    state_d = state_q; // hold by default
    case (state_q)
      IDLE:
      begin
        if (in_valid_i)
        begin
          state_d = LOAD; // request taken
        end
      end
      LOAD:
      begin
        state_d = skip_i ? DONE : CALC; // result already known on skip
      end
      CALC:
      begin
        if (last_i)
        begin
          state_d = DONE;
        end
      end
      DONE:
      begin
        if (out_ready_i)
        begin
          state_d = IDLE; // response consumed
        end
      end
      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge nreset)
  begin
    if (!nreset)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  assign in_ready_o  = (state_q == IDLE);
  assign out_valid_o = (state_q == DONE); // held while back-pressured
  assign load_o      = (state_q == IDLE) && in_valid_i; // input handshake
  assign step_o      = (state_q == CALC);

  // response may not be withdrawn before it is taken
  a_valid_hold: assert property (
    @(posedge clock) disable iff (!nreset) out_valid_o && !out_ready_i |=> out_valid_o
  ) else $error("out_valid dropped without handshake");

  // single item in flight
  a_one_in_flight: assert property (
    @(posedge clock) disable iff (!nreset) !(in_ready_o && out_valid_o)
  ) else $error("ready for input while a result waits");

endmodule

`default_nettype wire

// File: rtl/div_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module div_datapath (
  input  logic              clock,
  input  logic              nreset,
  input  div_pkg::div_req_t req_i,
  input  logic              load_i, // capture operands
  input  logic              step_i, // retire one quotient bit
  output logic              skip_o, // nothing to iterate
  output logic              last_o, // this step handles bit zero
  output div_pkg::div_rsp_t rsp_o
);
  import div_pkg::*;

  mag_t              a_mag_d;    // dividend magnitude from the request
  mag_t              b_mag_d;    // divisor magnitude from the request
  logic              lead_found;
  idx_t              lead_idx;
  mag_t              a_mag_q;
  mag_t              b_mag_q;
  mag_t              rem_q;      // partial remainder
  mag_t              quo_q;      // quotient magnitude
  logic              a_neg_q;
  logic              b_neg_q;
  logic              dbz_q;      // divisor was zero
  idx_t              idx_q;      // next dividend bit to bring down
  logic [DATA_W:0]   shifted;    // remainder with the next bit appended
  logic [DATA_W+1:0] trial;      // shifted minus divisor, top bit is borrow
  logic              sub_ok;
  mag_t              rem_mag;

  // absolute values, -(-2**31) wraps to 2**31 which fits as unsigned
  always_comb
  begin
    a_mag_d = req_i.dividend[DATA_W-1] ? mag_t'(-req_i.dividend) : mag_t'(req_i.dividend);
    b_mag_d = req_i.divisor[DATA_W-1] ? mag_t'(-req_i.divisor) : mag_t'(req_i.divisor);
  end

  lead_one_detect u_lead (
    .vec_i   (a_mag_d),
    .found_o (lead_found),
    .idx_o   (lead_idx)
  );

  // one restoring-division step
  always_comb
  begin
    shifted = {rem_q, a_mag_q[idx_q]};            // bring down next bit
    trial   = {1'b0, shifted} - {2'b00, b_mag_q};
    sub_ok  = ~trial[DATA_W+1];                   // non-negative result
  end

  always_ff @(posedge clock or negedge nreset)
  begin
    if (!nreset)
    begin
      a_neg_q <= 1'b0;
      b_neg_q <= 1'b0;
      dbz_q   <= 1'b0;
      idx_q   <= '0;
    end
    else if (load_i)
    begin
      a_neg_q <= req_i.dividend[DATA_W-1];
      b_neg_q <= req_i.divisor[DATA_W-1];
      dbz_q   <= (req_i.divisor == '0);
      idx_q   <= lead_found ? lead_idx : '0; // skip leading zeros
    end
    else if (step_i)
    begin
      idx_q   <= idx_q - 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (load_i)
    begin
      a_mag_q <= a_mag_d;
      b_mag_q <= b_mag_d;
      rem_q   <= '0;
      quo_q   <= '0; // bits above the start index stay zero
    end
    else if (step_i)
    begin
      rem_q        <= sub_ok ? trial[DATA_W-1:0] : shifted[DATA_W-1:0];
      quo_q[idx_q] <= sub_ok;
    end
  end

  assign skip_o = dbz_q | (a_mag_q == '0); // zero divisor or zero dividend
  assign last_o = (idx_q == '0);

  // sign fixup, q sign is xor of signs, r sign is the dividend's
  always_comb
  begin
    rem_mag = dbz_q ? a_mag_q : rem_q; // divide by zero hands back the dividend
    rsp_o.quotient = '0;
    if (!dbz_q)
    begin
      rsp_o.quotient = (a_neg_q ^ b_neg_q) ? -data_t'(quo_q) : data_t'(quo_q);
    end
    rsp_o.remainder   = a_neg_q ? -data_t'(rem_mag) : data_t'(rem_mag);
    rsp_o.div_by_zero = dbz_q;
  end

  // controller must stop stepping once bit zero is retired
  a_no_step_past_zero: assert property (
    @(posedge clock) disable iff (!nreset) step_i && last_o |=> !step_i
  ) else $error("step issued after the last quotient bit");

  a_load_step_excl: assert property (
    @(posedge clock) disable iff (!nreset) !(load_i && step_i)
  ) else $error("load and step in the same cycle");

endmodule

`default_nettype wire

// File: rtl/div_pkg.sv
`default_nettype none

package div_pkg;

  localparam int DATA_W = 32; // operand and result width
  localparam int IDX_W  = 5;  // enough to index any bit of a DATA_W word

  typedef logic signed [DATA_W-1:0] data_t; // two's-complement operand
  typedef logic [DATA_W-1:0]        mag_t;  // unsigned magnitude, holds 2**31
  typedef logic [IDX_W-1:0]         idx_t;  // bit position

  // request payload, 64 bits
  typedef struct packed {
    data_t dividend;
    data_t divisor;
  } div_req_t;

  // response payload, 65 bits
  typedef struct packed {
    data_t quotient;    // truncated toward zero
    data_t remainder;   // sign follows the dividend
    logic  div_by_zero; // quotient 0, remainder = dividend
  } div_rsp_t;

  // controller states
  typedef enum logic [1:0] {
    IDLE = 2'd0, // waiting for a request
    LOAD = 2'd1, // operands just latched
    CALC = 2'd2, // one quotient bit per clock
    DONE = 2'd3  // result held until taken
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/div_top.sv
`timescale 1ns/1ps
`default_nettype none

module div_top (
  input  logic              clock,
  input  logic              nreset,
  input  div_pkg::div_req_t req_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  output div_pkg::div_rsp_t rsp_o,
  output logic              out_valid_o,
  input  logic              out_ready_i
);

  logic load;  // ctrl to datapath
  logic step;
  logic skip;  // datapath to ctrl
  logic last;

  div_ctrl u_ctrl (
    .clock       (clock),
    .nreset      (nreset),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .skip_i      (skip),
    .last_i      (last),
    .load_o      (load),
    .step_o      (step)
  );

  div_datapath u_datapath (
    .clock  (clock),
    .nreset (nreset),
    .req_i  (req_i),
    .load_i (load),
    .step_i (step),
    .skip_o (skip),
    .last_o (last),
    .rsp_o  (rsp_o)
  );

endmodule

`default_nettype wire

// File: rtl/lead_one_detect.sv
`timescale 1ns/1ps
`default_nettype none

module lead_one_detect (
  input  div_pkg::mag_t vec_i,   // dividend magnitude
  output logic          found_o, // any bit set
  output div_pkg::idx_t idx_o    // position of top set bit
);
  import div_pkg::*;

  // priority encoder, the highest set bit wins
  always_comb
  begin
    idx_o = '0;
    for (int i = 0; i < DATA_W; i++)
    begin
      if (vec_i[i])
      begin
        idx_o = idx_t'(i); // later (higher) hits override lower ones
      end
    end
  end

  assign found_o = |vec_i; // low only for a zero magnitude

endmodule

`default_nettype wire

// File: sources.f
+incdir+tb
rtl/div_pkg.sv
rtl/lead_one_detect.sv
rtl/div_datapath.sv
rtl/div_ctrl.sv
rtl/div_top.sv
tb/tb_div_top.sv

// File: tb/div_vectors.svh
`ifndef DIV_VECTORS_SVH
`define DIV_VECTORS_SVH

// each row holds dividend, divisor, expected quotient, expected remainder
// and expected div_by_zero flag
typedef struct packed {
  data_t dividend;
  data_t divisor;
  data_t quotient;
  data_t remainder;
  logic  div_by_zero;
} vec_t;

localparam int NUM_VEC = 19;

localparam vec_t DIR_VECTORS [NUM_VEC] = '{
  '{ 32'sd100,          32'sd7,   32'sd14,          32'sd2,  1'b0}, // + / +
  '{-32'sd100,          32'sd7,  -32'sd14,         -32'sd2,  1'b0}, // - / +
  '{ 32'sd100,         -32'sd7,  -32'sd14,          32'sd2,  1'b0}, // + / -
  '{-32'sd100,         -32'sd7,   32'sd14,         -32'sd2,  1'b0}, // - / -
  '{ 32'sd3,            32'sd10,  32'sd0,           32'sd3,  1'b0}, // dividend < divisor
  '{-32'sd3,            32'sd10,  32'sd0,          -32'sd3,  1'b0},
  '{ 32'sd12345,        32'sd1,   32'sd12345,       32'sd0,  1'b0}, // divisor of one
  '{-32'sd12345,        32'sd1,  -32'sd12345,       32'sd0,  1'b0},
  '{ 32'sd0,            32'sd5,   32'sd0,           32'sd0,  1'b0}, // zero dividend, skip path
  '{ 32'sd0,           -32'sd5,   32'sd0,           32'sd0,  1'b0},
  '{ 32'sh8000_0000,   -32'sd1,   32'sh8000_0000,   32'sd0,  1'b0}, // wraps to itself
  '{ 32'sd42,           32'sd0,   32'sd0,           32'sd42, 1'b1}, // divide by zero
  '{-32'sd9,            32'sd0,   32'sd0,          -32'sd9,  1'b1},
  '{ 32'sd0,            32'sd0,   32'sd0,           32'sd0,  1'b1},
  '{ 32'sh7fff_ffff,    32'sd2,   32'sd1073741823,  32'sd1,  1'b0}, // full 31-bit run
  '{ 32'sh8000_0000,    32'sd2,  -32'sd1073741824,  32'sd0,  1'b0}, // full 32-bit run
  '{ 32'sh8000_0000,    32'sd3,  -32'sd715827882,  -32'sd2,  1'b0},
  '{ 32'sh7fff_ffff,    32'sh8000_0000, 32'sd0,     32'sh7fff_ffff, 1'b0},
  '{ 32'sh8000_0000,    32'sh8000_0000, 32'sd1,     32'sd0,  1'b0}
};

`endif

// File: tb/tb_div_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_div_top;
  import div_pkg::*;

`include "div_vectors.svh"

  localparam int CLK_PERIOD  = 4;           // ns
  localparam int NUM_RANDOM  = 200;
  localparam int MAX_LAT     = DATA_W + 2;  // accept to out_valid, worst case
  localparam int MAX_STALL   = 7;           // longest out_ready low stretch
  localparam int NUM_ITEMS   = NUM_VEC + NUM_RANDOM;
  // handshake cycles per item and reset
  localparam int MARGIN_NS   = NUM_ITEMS * 4 * CLK_PERIOD + 100 * CLK_PERIOD;
  localparam int WATCHDOG_NS = NUM_ITEMS * (MAX_LAT + MAX_STALL) * CLK_PERIOD + MARGIN_NS;

  logic     clock;
  logic     nreset;
  div_req_t req;
  logic     in_valid;
  logic     in_ready;
  div_rsp_t rsp;
  logic     out_valid;
  logic     out_ready;
  integer   seed;

  div_top UUT (
    .clock       (clock),
    .nreset      (nreset),
    .req_i       (req),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .rsp_o       (rsp),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  initial
  begin
    clock = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clock = ~clock;
    end
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_rsp(input div_rsp_t got, input div_rsp_t exp, input string what);
    if (got !== exp)
    begin
      abort_run($sformatf(
        "CHECK FAILED at %0t: %s, got q=%0d r=%0d dbz=%0b, expected q=%0d r=%0d dbz=%0b",
        $time, what, got.quotient, got.remainder, got.div_by_zero,
        exp.quotient, exp.remainder, exp.div_by_zero));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // truncating division, remainder follows the dividend
  function automatic div_rsp_t expected_rsp(input data_t a, input data_t b);
    div_rsp_t e;
    e.div_by_zero = (b == '0);
    if (b == '0)
    begin
      e.quotient  = '0;
      e.remainder = a; // dividend handed back
    end
    else if (b == -1)
    begin
      e.quotient  = -a; // two's-complement wrap for the most negative value
      e.remainder = '0;
    end
    else
    begin
      e.quotient  = a / b;
      e.remainder = a % b;
    end
    return e;
  endfunction

  // one full transaction with a random stall on the output side
  task automatic run_one(input data_t dividend, input data_t divisor, input div_rsp_t exp);
    int          cycles;
    int          stall;
    ctrl_state_t st;
    stall = $unsigned($random(seed)) % (MAX_STALL + 1);
    check_bit(in_ready, 1'b1, "in_ready in idle");
    req.dividend = dividend;
    req.divisor  = divisor;
    in_valid     = 1'b1;
    @(negedge clock); // accepted on the rising edge before
    in_valid = 1'b0;
    cycles   = 0;
    while (!out_valid)
    begin
      check_bit(in_ready, 1'b0, "in_ready while busy");
      if (cycles >= MAX_LAT)
      begin
        st = UUT.u_ctrl.state_q;
        abort_run($sformatf("no result within %0d cycles of acceptance at %0t, controller in %s",
                            MAX_LAT, $time, st.name()));
      end
      @(negedge clock);
      cycles++;
    end
    check_rsp(rsp, exp, $sformatf("%0d / %0d", dividend, divisor));
    check_bit(in_ready, 1'b0, "in_ready with result pending");
    repeat (stall)
    begin
      @(negedge clock);
      check_bit(out_valid, 1'b1, "out_valid under back-pressure");
      check_bit(in_ready, 1'b0, "in_ready under back-pressure");
      check_rsp(rsp, exp, "response under back-pressure");
    end
    out_ready = 1'b1;
    @(negedge clock); // output handshake done
    out_ready = 1'b0;
    check_bit(out_valid, 1'b0, "out_valid after handshake");
    check_bit(in_ready, 1'b1, "in_ready after handshake");
  endtask

  initial
  begin
    div_rsp_t exp_rsp;
    data_t    a;
    data_t    b;
    seed      = 32'hb41c1c66;
    nreset    = 1'b0;
    req       = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    repeat (5) @(negedge clock);
    nreset = 1'b1;
    @(negedge clock);
    check_bit(in_ready, 1'b1, "in_ready after reset");
    check_bit(out_valid, 1'b0, "out_valid after reset");
    for (int i = 0; i < NUM_VEC; i++)
    begin
      exp_rsp.quotient    = DIR_VECTORS[i].quotient;
      exp_rsp.remainder   = DIR_VECTORS[i].remainder;
      exp_rsp.div_by_zero = DIR_VECTORS[i].div_by_zero;
      run_one(DIR_VECTORS[i].dividend, DIR_VECTORS[i].divisor, exp_rsp);
    end
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      a = $random(seed) >>> ($unsigned($random(seed)) % DATA_W); // varied lengths
      b = $random(seed) >>> ($unsigned($random(seed)) % DATA_W);
      if (($random(seed) & 15) == 0)
      begin
        b = '0; // occasional divide by zero
      end
      run_one(a, b, expected_rsp(a, b));
    end
    $display("All tests passed");
    $finish;
  end

  // watchdog, sized from the number of items and worst-case latency
  initial
  begin
    #(WATCHDOG_NS);
    abort_run($sformatf("timeout, the run did not finish within %0d ns", WATCHDOG_NS));
  end

endmodule

`default_nettype wire
